//--- common/frontend_pkg.sv
package frontend_pkg;

    // fetch width and the counts derived from it
    localparam int fetch_width = 4;                   // instructions per fetch
    localparam int count_bits  = 3;                   // holds 0 to fetch_width
    localparam int slot_bits   = $clog2(fetch_width);
    localparam int addr_bits   = 32;

    typedef logic [addr_bits-1:0]  addr_t;            // byte address
    typedef logic [31:0]           inst_t;
    typedef logic [count_bits-1:0] count_t;
    typedef logic [slot_bits-1:0]  slot_t;

    // instruction buffer
    localparam int buffer_depth    = 16;
    localparam int spots_bits      = 5;               // free space, 0 to buffer_depth
    localparam int buffer_ptr_bits = $clog2(buffer_depth);

    typedef logic [spots_bits-1:0]      spots_t;
    typedef logic [buffer_ptr_bits-1:0] ptr_t;

    // predictor, direct mapped on word address bits
    localparam int btb_entries    = 16;
    localparam int btb_index_bits = 4;
    localparam int btb_tag_bits   = addr_bits - btb_index_bits - 2;

    typedef logic [btb_index_bits-1:0] btb_index_t;
    typedef logic [btb_tag_bits-1:0]   btb_tag_t;

    localparam logic [1:0] counter_reset = 2'b01;     // weakly not taken

    // major opcodes the front end cares about
    typedef enum logic [6:0] {
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        other  = 7'b0010011    // stands in for every other opcode
    } opcode_e;

    // one fetched instruction on its way to decode
    typedef struct packed {
        inst_t inst;
        addr_t pc;
        addr_t predicted_pc;   // where fetch went after this slot
        logic  taken;
        logic  is_jump;
    } fetch_packet_t;

endpackage

//--- common/predict_if.sv
`timescale 1ns/1ps

// per-slot lookup between fetch and the branch predictor
interface predict_if;

    frontend_pkg::addr_t [frontend_pkg::fetch_width-1:0] slot_pc;
    logic                [frontend_pkg::fetch_width-1:0] hit;
    logic                [frontend_pkg::fetch_width-1:0] predict_taken;
    frontend_pkg::addr_t [frontend_pkg::fetch_width-1:0] target;

    modport fetch (
        output slot_pc,
        input  hit,
        input  predict_taken,
        input  target
    );

    modport predictor (
        input  slot_pc,
        output hit,
        output predict_taken,
        output target
    );

endinterface

//--- source/priority_select.sv
`timescale 1ns/1ps

module priority_select #(
    parameter int width = 4
) (
    input  logic [width-1:0]         req,
    output logic [$clog2(width)-1:0] index,
    output logic                     found
);

    // lowest set bit wins
    always_comb begin
        index = '0;
        found = 1'b0;
        for (int i = 0; i < width; i++) begin
            if (req[i] && !found) begin
                index = i[$clog2(width)-1:0];
                found = 1'b1;
            end
        end
    end

endmodule

//--- fetch/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                                                  clock,
    input  logic                                                  reset,
    input  logic                                                  restore_valid,
    input  frontend_pkg::addr_t                                   restore_pc,
    predict_if.fetch                                              pred,
    output frontend_pkg::addr_t         [frontend_pkg::fetch_width-1:0] fetch_pc,
    input  frontend_pkg::inst_t         [frontend_pkg::fetch_width-1:0] cache_data,
    input  logic                        [frontend_pkg::fetch_width-1:0] cache_miss,
    input  frontend_pkg::spots_t                                  spots,
    output frontend_pkg::fetch_packet_t [frontend_pkg::fetch_width-1:0] packets,
    output frontend_pkg::count_t                                  count
);

    frontend_pkg::addr_t   pc;
    frontend_pkg::addr_t   next_pc;
    frontend_pkg::opcode_e slot_op [frontend_pkg::fetch_width];

    logic [frontend_pkg::fetch_width-1:0] slot_jump;
    logic [frontend_pkg::fetch_width-1:0] slot_taken;

    frontend_pkg::slot_t  miss_index;
    frontend_pkg::slot_t  taken_index;
    logic                 miss_found;
    logic                 taken_found;
    frontend_pkg::spots_t miss_limit;
    frontend_pkg::spots_t taken_limit;
    frontend_pkg::spots_t keep;
    frontend_pkg::slot_t  last_slot;

    // consecutive word addresses from the current pc
    always_comb begin
        for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
            fetch_pc[i] = pc + frontend_pkg::addr_t'(4 * i);
        end
    end

    assign pred.slot_pc = fetch_pc;   // predictor looks up the same slots

    // opcode class of each returned word
    always_comb begin
        for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
            case (cache_data[i][6:0])
                frontend_pkg::branch: slot_op[i] = frontend_pkg::branch;
                frontend_pkg::jal:    slot_op[i] = frontend_pkg::jal;
                frontend_pkg::jalr:   slot_op[i] = frontend_pkg::jalr;
                default:              slot_op[i] = frontend_pkg::other;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
            slot_jump[i]  = (slot_op[i] == frontend_pkg::jal) || (slot_op[i] == frontend_pkg::jalr);
            // jumps only need a btb hit, branches also need the counter
            slot_taken[i] = pred.hit[i] && (slot_jump[i] ||
                            (slot_op[i] == frontend_pkg::branch && pred.predict_taken[i]));
        end
    end

    always_comb begin
        for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
            packets[i].inst         = cache_data[i];
            packets[i].pc           = fetch_pc[i];
            packets[i].predicted_pc = slot_taken[i] ? pred.target[i] : fetch_pc[i] + 32'd4;
            packets[i].taken        = slot_taken[i];
            packets[i].is_jump      = slot_jump[i];
        end
    end

    priority_select #(
        .width(frontend_pkg::fetch_width)
    ) u_miss_select (
        .req   (cache_miss),
        .index (miss_index),
        .found (miss_found)
    );

    priority_select #(
        .width(frontend_pkg::fetch_width)
    ) u_taken_select (
        .req   (slot_taken),
        .index (taken_index),
        .found (taken_found)
    );

    // a miss drops its own slot, a taken slot is kept and ends the group
    assign miss_limit  = miss_found ? frontend_pkg::spots_t'(miss_index)
                                    : frontend_pkg::spots_t'(frontend_pkg::fetch_width);
    assign taken_limit = taken_found ? frontend_pkg::spots_t'(taken_index) + frontend_pkg::spots_t'(1)
                                     : frontend_pkg::spots_t'(frontend_pkg::fetch_width);

    always_comb begin
        keep = miss_limit;
        if (taken_limit < keep) begin
            keep = taken_limit;
        end
        if (spots < keep) begin
            keep = spots;   // never more than the buffer can take
        end
    end

    assign count = frontend_pkg::count_t'(keep);

    // steer from the last kept slot, hold when nothing was kept
    assign last_slot = frontend_pkg::slot_t'(count - frontend_pkg::count_t'(1));
    assign next_pc   = (count == '0) ? pc : packets[last_slot].predicted_pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (restore_valid) begin
            pc <= restore_pc;   // back end redirect wins
        end else begin
            pc <= next_pc;
        end
    end

endmodule

//--- fetch/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic                clock,
    input  logic                reset,
    predict_if.predictor        pred,
    input  logic                update_valid,
    input  frontend_pkg::addr_t update_pc,
    input  logic                update_taken,
    input  frontend_pkg::addr_t update_target
);

    logic                   btb_valid   [frontend_pkg::btb_entries];
    frontend_pkg::btb_tag_t btb_tag     [frontend_pkg::btb_entries];
    frontend_pkg::addr_t    btb_target  [frontend_pkg::btb_entries];
    logic [1:0]             counter     [frontend_pkg::btb_entries];

    frontend_pkg::btb_index_t update_index;
    frontend_pkg::btb_tag_t   update_tag;

    // word address bits select the set
    function automatic frontend_pkg::btb_index_t index_of(input frontend_pkg::addr_t addr);
        return addr[frontend_pkg::btb_index_bits+1:2];
    endfunction

    function automatic frontend_pkg::btb_tag_t tag_of(input frontend_pkg::addr_t addr);
        return addr[frontend_pkg::addr_bits-1:frontend_pkg::btb_index_bits+2];
    endfunction

    // all slots looked up in parallel
    always_comb begin
        for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
            pred.hit[i]           = btb_valid[index_of(pred.slot_pc[i])] &&
                                    (btb_tag[index_of(pred.slot_pc[i])] == tag_of(pred.slot_pc[i]));
            pred.predict_taken[i] = counter[index_of(pred.slot_pc[i])][1];
            pred.target[i]        = btb_target[index_of(pred.slot_pc[i])];
        end
    end

    assign update_index = index_of(update_pc);
    assign update_tag   = tag_of(update_pc);

    // valid bits and counters
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < frontend_pkg::btb_entries; i++) begin
                btb_valid[i] <= 1'b0;
                counter[i]   <= frontend_pkg::counter_reset;
            end
        end else if (update_valid) begin
            if (update_taken) begin
                btb_valid[update_index] <= 1'b1;
                if (counter[update_index] != 2'b11) begin
                    counter[update_index] <= counter[update_index] + 2'd1;
                end
            end else if (counter[update_index] != 2'b00) begin
                counter[update_index] <= counter[update_index] - 2'd1;
            end
        end
    end

    // tag and target only change on a taken update
    always_ff @(posedge clock) begin
        if (update_valid && update_taken) begin
            btb_tag[update_index]    <= update_tag;
            btb_target[update_index] <= update_target;
        end
    end

endmodule

//--- source/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer (
    input  logic                                                  clock,
    input  logic                                                  reset,
    input  logic                                                  flush,
    input  frontend_pkg::fetch_packet_t [frontend_pkg::fetch_width-1:0] packets,
    input  frontend_pkg::count_t                                  count,
    output frontend_pkg::spots_t                                  spots,
    output frontend_pkg::fetch_packet_t                           out_packet,
    output logic                                                  out_valid,
    input  logic                                                  out_ready
);

    frontend_pkg::fetch_packet_t entries [frontend_pkg::buffer_depth];
    frontend_pkg::ptr_t          wr_addr [frontend_pkg::fetch_width];

    frontend_pkg::ptr_t   head;
    frontend_pkg::ptr_t   tail;
    frontend_pkg::spots_t occupancy;
    logic                 pop;

    assign out_valid  = (occupancy != '0);
    assign out_packet = entries[head];   // head is visible without a pop
    assign pop        = out_valid && out_ready;
    assign spots      = frontend_pkg::spots_t'(frontend_pkg::buffer_depth) - occupancy;

    // slots land in order starting at the tail, wrapping around
    always_comb begin
        for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
            wr_addr[i] = tail + frontend_pkg::ptr_t'(i);
        end
    end

    always_ff @(posedge clock) begin
        if (!flush) begin
            for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
                if (frontend_pkg::count_t'(i) < count) begin
                    entries[wr_addr[i]] <= packets[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;   // offered packets are dropped too
        end else begin
            tail      <= tail + frontend_pkg::ptr_t'(count);
            occupancy <= occupancy + frontend_pkg::spots_t'(count)
                         - frontend_pkg::spots_t'(pop);
            if (pop) begin
                head <= head + frontend_pkg::ptr_t'(1);
            end
        end
    end

endmodule

//--- source/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                                          clock,
    input  logic                                          reset,
    output frontend_pkg::addr_t [frontend_pkg::fetch_width-1:0] fetch_pc,
    input  frontend_pkg::inst_t [frontend_pkg::fetch_width-1:0] cache_data,
    input  logic                [frontend_pkg::fetch_width-1:0] cache_miss,
    input  logic                                          restore_valid,
    input  frontend_pkg::addr_t                           restore_pc,
    input  logic                                          update_valid,
    input  frontend_pkg::addr_t                           update_pc,
    input  logic                                          update_taken,
    input  frontend_pkg::addr_t                           update_target,
    input  logic                                          out_ready,
    output logic                                          out_valid,
    output frontend_pkg::inst_t                           out_inst,
    output frontend_pkg::addr_t                           out_pc,
    output frontend_pkg::addr_t                           out_predicted_pc,
    output logic                                          out_taken,
    output logic                                          out_is_jump
);

    predict_if pred ();

    frontend_pkg::fetch_packet_t [frontend_pkg::fetch_width-1:0] packets;
    frontend_pkg::count_t        count;
    frontend_pkg::spots_t        spots;
    frontend_pkg::fetch_packet_t out_packet;

    fetch_stage u_fetch (
        .clock         (clock),
        .reset         (reset),
        .restore_valid (restore_valid),
        .restore_pc    (restore_pc),
        .pred          (pred),
        .fetch_pc      (fetch_pc),
        .cache_data    (cache_data),
        .cache_miss    (cache_miss),
        .spots         (spots),
        .packets       (packets),
        .count         (count)
    );

    branch_predictor u_predictor (
        .clock         (clock),
        .reset         (reset),
        .pred          (pred),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target)
    );

    inst_buffer u_buffer (
        .clock      (clock),
        .reset      (reset),
        .flush      (restore_valid),   // a restore drops everything fetched so far
        .packets    (packets),
        .count      (count),
        .spots      (spots),
        .out_packet (out_packet),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    assign out_inst         = out_packet.inst;
    assign out_pc           = out_packet.pc;
    assign out_predicted_pc = out_packet.predicted_pc;
    assign out_taken        = out_packet.taken;
    assign out_is_jump      = out_packet.is_jump;

endmodule

//--- testbench/frontend_props.sv
`timescale 1ns/1ps

module fetch_props (
    input logic                                 clock,
    input logic                                 reset,
    input logic                                 restore_valid,
    input frontend_pkg::addr_t                  restore_pc,
    input frontend_pkg::addr_t                  pc,
    input logic [frontend_pkg::fetch_width-1:0] cache_miss,
    input frontend_pkg::spots_t                 spots,
    input frontend_pkg::count_t                 count
);

    // never offer more than the buffer can take
    count_fits: assert property (@(posedge clock) disable iff (reset)
        frontend_pkg::spots_t'(count) <= spots)
        else $error("fetch kept %0d words with %0d free entries", count, spots);

    miss_stops: assert property (@(posedge clock) disable iff (reset)
        cache_miss[0] |-> count == '0)
        else $error("fetch kept words although slot 0 missed");

    restore_lands: assert property (@(posedge clock) disable iff (reset)
        restore_valid |=> pc == $past(restore_pc))
        else $error("pc did not take the restore address");

endmodule

bind fetch_stage fetch_props u_props (
    .clock         (clock),
    .reset         (reset),
    .restore_valid (restore_valid),
    .restore_pc    (restore_pc),
    .pc            (pc),
    .cache_miss    (cache_miss),
    .spots         (spots),
    .count         (count)
);

//--- testbench/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

    logic                                                  clock = 1'b0;
    logic                                                  reset;
    frontend_pkg::addr_t [frontend_pkg::fetch_width-1:0]   fetch_pc;
    frontend_pkg::inst_t [frontend_pkg::fetch_width-1:0]   cache_data;
    logic                [frontend_pkg::fetch_width-1:0]   cache_miss = '0;
    logic                restore_valid;
    frontend_pkg::addr_t restore_pc;
    logic                update_valid;
    frontend_pkg::addr_t update_pc;
    logic                update_taken;
    frontend_pkg::addr_t update_target;
    logic                out_ready;
    logic                out_valid;
    frontend_pkg::inst_t out_inst;
    frontend_pkg::addr_t out_pc;
    frontend_pkg::addr_t out_predicted_pc;
    logic                out_taken;
    logic                out_is_jump;

    frontend_pkg::inst_t mem [256];   // 1 KB program image
    frontend_pkg::addr_t exp_pc;
    logic [31:0]         rng = 32'ha8e5_ecc7;
    int                  cur_miss = 0;    // miss rate in percent for the running test
    int                  test_errors;
    int                  total_errors = 0;
    int                  passed = 0;
    int                  failed = 0;

    // test table
    string               test_name   [$];
    int                  miss_pct    [$];
    logic [7:0]          ready_duty  [$];   // out_ready pattern with one bit per cycle
    int                  stall_len   [$];
    logic                has_restore [$];
    frontend_pkg::addr_t restore_to  [$];
    int                  drain_len   [$];
    int                  upd_row     [$];   // row an update pulse belongs to
    frontend_pkg::addr_t upd_pc      [$];
    logic                upd_taken   [$];
    frontend_pkg::addr_t upd_target  [$];

    // reference copy of the predictor
    logic                   m_valid   [frontend_pkg::btb_entries];
    frontend_pkg::btb_tag_t m_tag     [frontend_pkg::btb_entries];
    frontend_pkg::addr_t    m_target  [frontend_pkg::btb_entries];
    logic [1:0]             m_counter [frontend_pkg::btb_entries];

    frontend_top u_dut (
        .clock            (clock),
        .reset            (reset),
        .fetch_pc         (fetch_pc),
        .cache_data       (cache_data),
        .cache_miss       (cache_miss),
        .restore_valid    (restore_valid),
        .restore_pc       (restore_pc),
        .update_valid     (update_valid),
        .update_pc        (update_pc),
        .update_taken     (update_taken),
        .update_target    (update_target),
        .out_ready        (out_ready),
        .out_valid        (out_valid),
        .out_inst         (out_inst),
        .out_pc           (out_pc),
        .out_predicted_pc (out_predicted_pc),
        .out_taken        (out_taken),
        .out_is_jump      (out_is_jump)
    );

    always #4 clock = ~clock;

    // memory answers in the same cycle
    for (genvar i = 0; i < frontend_pkg::fetch_width; i++) begin : g_mem
        assign cache_data[i] = mem[fetch_pc[i][9:2]];
    end

    always @(posedge clock) begin
        #1;
        for (int i = 0; i < frontend_pkg::fetch_width; i++) begin
            rng = xorshift(rng);
            cache_miss[i] = (rng % 32'd100) < 32'(cur_miss);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'h5a, 8'(i * 7), 9'(i), frontend_pkg::other};
        end
        mem[8'h40] = {25'h00a_4000, frontend_pkg::branch};   // branch at 0x100
        mem[8'h51] = {25'h0c0_0000, frontend_pkg::jal};      // jal at 0x144
    endtask

    task automatic add_test(input string name, input int miss, input logic [7:0] duty,
                            input int stall, input logic restore, input frontend_pkg::addr_t to,
                            input int drain);
        test_name.push_back(name);
        miss_pct.push_back(miss);
        ready_duty.push_back(duty);
        stall_len.push_back(stall);
        has_restore.push_back(restore);
        restore_to.push_back(to);
        drain_len.push_back(drain);
    endtask

    task automatic add_update(input int row, input frontend_pkg::addr_t pc, input logic taken,
                              input frontend_pkg::addr_t target);
        upd_row.push_back(row);
        upd_pc.push_back(pc);
        upd_taken.push_back(taken);
        upd_target.push_back(target);
    endtask

    task automatic fill_table();
        add_test("reset_stream", 0, 8'hff, 0, 1'b0, 32'h0, 20);
        add_test("random_miss", 30, 8'b1101_0111, 0, 1'b0, 32'h0, 24);
        add_test("backpressure", 10, 8'hff, 40, 1'b0, 32'h0, 30);
        add_test("restore_flush", 15, 8'hff, 0, 1'b1, 32'h2a0, 12);
        add_test("branch_taken", 15, 8'hff, 0, 1'b1, 32'h0f8, 8);
        add_test("jal_taken", 15, 8'hff, 0, 1'b1, 32'h13c, 8);
        add_test("branch_cleared", 15, 8'hff, 0, 1'b1, 32'h0f8, 8);
        add_update(4, 32'h100, 1'b1, 32'h200);
        add_update(4, 32'h100, 1'b1, 32'h200);
        add_update(5, 32'h144, 1'b1, 32'h300);
        add_update(6, 32'h100, 1'b0, 32'h0);
        add_update(6, 32'h100, 1'b0, 32'h0);
    endtask

    task automatic reset_model();
        for (int i = 0; i < frontend_pkg::btb_entries; i++) begin
            m_valid[i]   = 1'b0;
            m_tag[i]     = '0;
            m_target[i]  = '0;
            m_counter[i] = frontend_pkg::counter_reset;
        end
    endtask

    // taken updates fill the entry and move the saturating counter up
    task automatic train_model(input frontend_pkg::addr_t pc, input logic taken,
                               input frontend_pkg::addr_t target);
        logic [3:0] idx;
        idx = pc[5:2];
        if (taken) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = pc[31:6];
            m_target[idx] = target;
            if (m_counter[idx] != 2'b11) begin
                m_counter[idx] = m_counter[idx] + 2'd1;
            end
        end else if (m_counter[idx] != 2'b00) begin
            m_counter[idx] = m_counter[idx] - 2'd1;
        end
    endtask

    function automatic logic jump_at(input frontend_pkg::addr_t pc);
        logic [6:0] op;
        op = mem[pc[9:2]][6:0];
        return op == frontend_pkg::jal || op == frontend_pkg::jalr;
    endfunction

    function automatic logic taken_at(input frontend_pkg::addr_t pc);
        logic [3:0] idx;
        logic       hit;
        logic       branch;
        idx    = pc[5:2];
        hit    = m_valid[idx] && m_tag[idx] == pc[31:6];
        branch = mem[pc[9:2]][6:0] == frontend_pkg::branch;
        return hit && (jump_at(pc) || (branch && m_counter[idx][1]));
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s %s: expected %h, actual %h", test, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_dequeue(input string test);
        logic                taken;
        frontend_pkg::addr_t predicted;
        taken     = taken_at(exp_pc);
        predicted = taken ? m_target[exp_pc[5:2]] : exp_pc + 32'd4;
        check_value(test, "pc", exp_pc, out_pc);
        check_value(test, "inst", mem[exp_pc[9:2]], out_inst);
        check_value(test, "taken", 32'(taken), 32'(out_taken));
        check_value(test, "predicted_pc", predicted, out_predicted_pc);
        check_value(test, "is_jump", 32'(jump_at(exp_pc)), 32'(out_is_jump));
        exp_pc = predicted;   // the model decides where the stream goes
    endtask

    task automatic send_update(input frontend_pkg::addr_t pc, input logic taken,
                               input frontend_pkg::addr_t target);
        update_valid  = 1'b1;
        update_pc     = pc;
        update_taken  = taken;
        update_target = target;
        @(posedge clock);
        #1;
        update_valid = 1'b0;
        train_model(pc, taken, target);
    endtask

    task automatic run_test(input int t);
        int done;
        int cycle;
        test_errors = 0;
        cur_miss    = miss_pct[t];
        for (int u = 0; u < upd_row.size(); u++) begin
            if (upd_row[u] == t) begin
                send_update(upd_pc[u], upd_taken[u], upd_target[u]);
            end
        end
        if (has_restore[t]) begin
            restore_valid = 1'b1;
            restore_pc    = restore_to[t];
            @(posedge clock);
            #1;
            restore_valid = 1'b0;
            exp_pc        = restore_to[t];
        end
        repeat (stall_len[t]) begin
            @(posedge clock);
            #1;
        end
        if (stall_len[t] > 0) begin
            // a full buffer holds the next buffer_depth words and fetch waits right after them
            check_value(test_name[t], "out_valid", 32'd1, 32'(out_valid));
            check_value(test_name[t], "fetch_pc",
                        exp_pc + 32'(4 * frontend_pkg::buffer_depth), fetch_pc[0]);
        end
        done  = 0;
        cycle = 0;
        while (done < drain_len[t]) begin
            out_ready = ready_duty[t][cycle[2:0]];
            @(negedge clock);   // outputs have settled before the pop at the next edge
            if (out_valid && out_ready) begin
                check_dequeue(test_name[t]);
                done++;
            end
            @(posedge clock);
            #1;
            cycle++;
        end
        out_ready = 1'b0;
        total_errors += test_errors;
        if (test_errors == 0) begin
            passed++;
            $display("test %s passed, %0d instructions", test_name[t], done);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", test_name[t], test_errors);
        end
    endtask

    initial begin
        reset         = 1'b1;
        restore_valid = 1'b0;
        restore_pc    = '0;
        update_valid  = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        update_target = '0;
        out_ready     = 1'b0;
        exp_pc        = '0;
        build_program();
        reset_model();
        fill_table();
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, total_errors);
        if (failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the drain lengths in the table
    initial begin
        int limit;
        limit = 0;
        #1;
        foreach (drain_len[t]) begin
            limit += drain_len[t] * 20;
        end
        repeat (limit + 5) @(posedge clock);
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- project.f
common/frontend_pkg.sv
common/predict_if.sv
source/priority_select.sv
fetch/fetch_stage.sv
fetch/branch_predictor.sv
source/inst_buffer.sv
source/frontend_top.sv
testbench/frontend_props.sv
testbench/frontend_tb.sv

//--- run.sh
#!/bin/sh
# build the front end and its testbench with verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module frontend_tb -f project.f -o frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/frontend_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
